//--- verilog/cmo_cfg_pkg.sv
// Cache geometry constants and vector types for addresses, sets, tags, ways and lines
`default_nettype none

package cmo_cfg_pkg;

    // Geometry of the single-bank write-back data cache
    localparam int unsigned CMO_SETS     = 8;
    localparam int unsigned CMO_WAYS     = 4;

    // Request address split into tag, set and line offset
    localparam int unsigned CMO_OFFSET_W = 4;
    localparam int unsigned CMO_SET_W    = 3;
    localparam int unsigned CMO_TAG_W    = 9;
    localparam int unsigned CMO_ADDR_W   = 16;

    // Line number is the address without its offset
    localparam int unsigned CMO_NLINE_W  = CMO_TAG_W + CMO_SET_W;

    // Request address as seen by the handler
    typedef logic [CMO_ADDR_W-1:0]  addr_t;

    // Directory set index
    typedef logic [CMO_SET_W-1:0]   set_t;

    // Directory tag
    typedef logic [CMO_TAG_W-1:0]   tag_t;

    // One bit per way, used one-hot or as a mask
    typedef logic [CMO_WAYS-1:0]    way_vec_t;

    // Tag in the upper bits, set in the lower bits
    typedef logic [CMO_NLINE_W-1:0] nline_t;

endpackage

`default_nettype wire

//--- verilog/cmo_if_pkg.sv
// Operation enum and packed structs for requester, status, directory and flush ports
`default_nettype none

package cmo_if_pkg;

    import cmo_cfg_pkg::*;

    // Maintenance operations accepted from the requester
    typedef enum logic [2:0] {
        CMO_FENCE,
        CMO_INVAL_NLINE,
        CMO_INVAL_ALL,
        CMO_FLUSH_NLINE,
        CMO_FLUSH_ALL
    } cmo_op_e;

    typedef struct packed {
        cmo_op_e op;
        addr_t   addr;
    } cmo_req_t;

    // Idle flags of the neighbouring cache blocks
    typedef struct packed {
        logic wbuf_empty;
        logic mshr_empty;
        logic refill_busy;
        logic rtab_empty;
        logic ctrl_empty;
    } cache_status_t;

    // Directory lookup of one line by set and tag
    typedef struct packed {
        logic valid;
        set_t set;
        tag_t tag;
    } dir_nline_req_t;

    // Hit way is all zeros on a miss
    typedef struct packed {
        way_vec_t hit_way;
        logic     dirty;
    } dir_nline_rsp_t;

    // Directory read of one entry by set and way
    typedef struct packed {
        logic     valid;
        set_t     set;
        way_vec_t way;
    } dir_entry_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_entry_rsp_t;

    // Clears the valid bit of every way set in the mask
    typedef struct packed {
        logic     valid;
        set_t     set;
        way_vec_t way;
    } dir_inval_t;

    // Write-back request toward the flush controller
    typedef struct packed {
        nline_t   nline;
        way_vec_t way;
    } flush_req_t;

endpackage

`default_nettype wire

//--- verilog/cmo_scan_cnt.sv
// Set counter and one-hot way rotator walking every directory entry
`default_nettype none
`timescale 1ns/1ps

module cmo_scan_cnt
    import cmo_cfg_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_ni,

    input  logic     scan_reset_i,
    input  logic     scan_step_i,

    output set_t     set_o,
    output way_vec_t way_o,
    output logic     set_last_o,
    output logic     way_last_o
);

    set_t     set_q;
    way_vec_t way_q;

    assign set_last_o = (set_q == set_t'(CMO_SETS - 1));
    assign way_last_o = way_q[CMO_WAYS-1];

    assign set_o = set_q;
    assign way_o = way_q;

    // Way-minor order, the set moves on once the last way has been visited
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            set_q <= '0;
            way_q <= way_vec_t'(1);
        end else if (scan_reset_i) begin
            set_q <= '0;
            way_q <= way_vec_t'(1);
        end else if (scan_step_i) begin
            if (way_last_o) begin
                way_q <= way_vec_t'(1);
                set_q <= set_last_o ? '0 : set_t'(set_q + 1'b1);
            end else begin
                way_q <= {way_q[CMO_WAYS-2:0], 1'b0};
            end
        end
    end

    // Directory checks rely on selecting exactly one way
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot(way_q))
    else $error("cmo_scan_cnt: way vector is not one-hot");

endmodule

`default_nettype wire

//--- verilog/cmo_flush_fifo.sv
// Register-array flush request queue with fall-through when empty
`default_nettype none
`timescale 1ns/1ps

module cmo_flush_fifo
    import cmo_if_pkg::*;
#(
    parameter int unsigned DEPTH = 3
) (
    input  logic       clk_i,
    input  logic       rst_ni,

    input  logic       push_i,
    output logic       push_ok_o,
    input  flush_req_t push_data_i,

    input  logic       pop_i,
    output logic       pop_ok_o,
    output flush_req_t pop_data_o
);

    typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

    flush_req_t mem_q [DEPTH];
    ptr_t       rd_ptr_q;
    ptr_t       wr_ptr_q;
    cnt_t       count_q;
    logic       empty;
    logic       bypass;
    logic       do_push;
    logic       do_pop;

    function automatic ptr_t ptr_next(ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr_t'(ptr + 1'b1);
    endfunction

    assign empty     = (count_q == '0);
    assign push_ok_o = (count_q != cnt_t'(DEPTH));

    // An empty queue shows the incoming request directly
    assign pop_ok_o   = ~empty | push_i;
    assign pop_data_o = empty ? push_data_i : mem_q[rd_ptr_q];

    // Taken in the same cycle it arrives, so it never lands in the array
    assign bypass  = empty & push_i & pop_i;
    assign do_push = push_i & ~bypass;
    assign do_pop  = pop_i & ~empty;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= cnt_t'(count_q + 1'b1);
                2'b01:   count_q <= cnt_t'(count_q - 1'b1);
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // The producer must respect the free-space flag
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> push_ok_o)
    else $error("cmo_flush_fifo: push while full");

endmodule

`default_nettype wire

//--- verilog/cmo_fsm.sv
// Maintenance request FSM for fences, line and whole-cache invalidations and flushes
`default_nettype none
`timescale 1ns/1ps

module cmo_fsm
    import cmo_cfg_pkg::*, cmo_if_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,

    input  logic           req_valid_i,
    input  cmo_req_t       req_i,
    output logic           req_ready_o,
    output logic           req_wait_o,

    input  cache_status_t  status_i,
    output logic           wbuf_flush_all_o,

    output dir_nline_req_t dir_nline_req_o,
    input  dir_nline_rsp_t dir_nline_rsp_i,
    output dir_entry_req_t dir_entry_req_o,
    input  dir_entry_rsp_t dir_entry_rsp_i,
    output dir_inval_t     dir_inval_o,

    output logic           scan_reset_o,
    output logic           scan_step_o,
    input  set_t           scan_set_i,
    input  way_vec_t       scan_way_i,
    input  logic           scan_set_last_i,
    input  logic           scan_way_last_i,

    output logic           flush_push_o,
    input  logic           flush_push_ok_i,
    output flush_req_t     flush_req_o,
    input  logic           flush_busy_i,
    input  logic           flush_empty_i
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_FENCE_WAIT,
        ST_DRAIN_WAIT,
        ST_INVAL_CHECK,
        ST_INVAL_LINE,
        ST_INVAL_ALL,
        ST_FLUSH_LINE,
        ST_FLUSH_WALK,
        ST_FLUSH_LAST
    } state_e;

    state_e   state_q, state_d;
    cmo_op_e  op_q, op_d;
    nline_t   nline_q, nline_d;
    logic     pend_q, pend_d;
    set_t     pend_set_q, pend_set_d;
    way_vec_t pend_way_q, pend_way_d;
    set_t     line_set;
    tag_t     line_tag;
    logic     drained;
    logic     nline_hit;
    logic     walk_issue;

    function automatic state_e first_state(cmo_op_e op);
        state_e st;
        case (op)
            CMO_INVAL_NLINE: st = ST_INVAL_CHECK;
            CMO_INVAL_ALL:   st = ST_INVAL_ALL;
            CMO_FLUSH_NLINE: st = ST_FLUSH_LINE;
            CMO_FLUSH_ALL:   st = ST_FLUSH_WALK;
            default:         st = ST_IDLE;
        endcase
        return st;
    endfunction

    assign line_set  = nline_q[CMO_SET_W-1:0];
    assign line_tag  = nline_q[CMO_NLINE_W-1:CMO_SET_W];
    assign nline_hit = |dir_nline_rsp_i.hit_way;

    // No miss, refill or replay may be in flight while the directory is touched
    assign drained = status_i.mshr_empty & ~status_i.refill_busy &
                     status_i.rtab_empty & status_i.ctrl_empty;

    assign req_ready_o  = (state_q == ST_IDLE);
    assign req_wait_o   = (state_q == ST_FENCE_WAIT) | (state_q == ST_DRAIN_WAIT);
    assign scan_reset_o = (state_q == ST_IDLE);

    // Next entry check only when the queue still has room for a push one cycle later
    assign walk_issue = (state_q == ST_FLUSH_WALK) & flush_push_ok_i & ~flush_push_o;

    // Result of the check issued in the previous cycle
    always_comb begin
        flush_push_o = 1'b0;
        flush_req_o  = '{nline: {dir_entry_rsp_i.tag, pend_set_q}, way: pend_way_q};
        if (pend_q) begin
            if (op_q == CMO_FLUSH_NLINE) begin
                flush_push_o = nline_hit & dir_nline_rsp_i.dirty;
                flush_req_o  = '{nline: nline_q, way: dir_nline_rsp_i.hit_way};
            end else begin
                flush_push_o = dir_entry_rsp_i.valid & dir_entry_rsp_i.dirty;
            end
        end
    end

    always_comb begin
        state_d    = state_q;
        op_d       = op_q;
        nline_d    = nline_q;
        pend_d     = 1'b0;
        pend_set_d = pend_set_q;
        pend_way_d = pend_way_q;

        wbuf_flush_all_o = 1'b0;
        scan_step_o      = 1'b0;
        dir_nline_req_o  = '{valid: 1'b0, set: line_set, tag: line_tag};
        dir_entry_req_o  = '{valid: 1'b0, set: scan_set_i, way: scan_way_i};
        dir_inval_o      = '{valid: 1'b0, set: line_set, way: dir_nline_rsp_i.hit_way};

        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    if (req_i.op == CMO_FENCE) begin
                        wbuf_flush_all_o = status_i.rtab_empty;
                        if (!(status_i.wbuf_empty && status_i.rtab_empty)) begin
                            state_d = ST_FENCE_WAIT;
                        end
                    end else begin
                        op_d    = req_i.op;
                        nline_d = req_i.addr[CMO_ADDR_W-1:CMO_OFFSET_W];
                        // Invalidate-all counts its sets in the set field
                        if (req_i.op == CMO_INVAL_ALL) begin
                            nline_d[CMO_SET_W-1:0] = '0;
                        end
                        state_d = drained ? first_state(req_i.op) : ST_DRAIN_WAIT;
                    end
                end
            end
            ST_FENCE_WAIT: begin
                wbuf_flush_all_o = status_i.rtab_empty;
                if (status_i.wbuf_empty && status_i.rtab_empty) begin
                    state_d = ST_IDLE;
                end
            end
            ST_DRAIN_WAIT: begin
                if (drained) begin
                    state_d = first_state(op_q);
                end
            end
            ST_INVAL_CHECK: begin
                dir_nline_req_o.valid = 1'b1;
                state_d = ST_INVAL_LINE;
            end
            ST_INVAL_LINE: begin
                dir_inval_o.valid = nline_hit;
                state_d = ST_IDLE;
            end
            ST_INVAL_ALL: begin
                dir_inval_o = '{valid: 1'b1, set: line_set, way: '1};
                nline_d[CMO_SET_W-1:0] = set_t'(line_set + 1'b1);
                if (line_set == set_t'(CMO_SETS - 1)) begin
                    state_d = ST_IDLE;
                end
            end
            ST_FLUSH_LINE: begin
                if (flush_push_ok_i) begin
                    dir_nline_req_o.valid = 1'b1;
                    pend_d  = 1'b1;
                    state_d = ST_FLUSH_LAST;
                end
            end
            ST_FLUSH_WALK: begin
                if (walk_issue) begin
                    dir_entry_req_o.valid = 1'b1;
                    scan_step_o = 1'b1;
                    pend_d      = 1'b1;
                    pend_set_d  = scan_set_i;
                    pend_way_d  = scan_way_i;
                    if (scan_set_last_i && scan_way_last_i) begin
                        state_d = ST_FLUSH_LAST;
                    end
                end
            end
            ST_FLUSH_LAST: begin
                // Done once every queued write-back has reached the flush controller
                if (flush_empty_i && !flush_busy_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= ST_IDLE;
            pend_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            pend_q  <= pend_d;
        end
    end

    always_ff @(posedge clk_i) begin
        op_q       <= op_d;
        nline_q    <= nline_d;
        pend_set_q <= pend_set_d;
        pend_way_q <= pend_way_d;
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_valid_i |-> (state_q == ST_IDLE))
    else $error("cmo_fsm: request received while busy");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        state_q inside {ST_IDLE, ST_FENCE_WAIT, ST_DRAIN_WAIT, ST_INVAL_CHECK, ST_INVAL_LINE,
                        ST_INVAL_ALL, ST_FLUSH_LINE, ST_FLUSH_WALK, ST_FLUSH_LAST})
    else $error("cmo_fsm: illegal state");

endmodule

`default_nettype wire

//--- verilog/cmo_handler.sv
// Maintenance handler top joining the request FSM, entry walker and flush queue
`default_nettype none
`timescale 1ns/1ps

module cmo_handler
    import cmo_cfg_pkg::*, cmo_if_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,

    input  logic           req_valid_i,
    input  cmo_req_t       req_i,
    output logic           req_ready_o,
    output logic           req_wait_o,

    input  cache_status_t  status_i,
    output logic           wbuf_flush_all_o,

    output dir_nline_req_t dir_nline_req_o,
    input  dir_nline_rsp_t dir_nline_rsp_i,
    output dir_entry_req_t dir_entry_req_o,
    input  dir_entry_rsp_t dir_entry_rsp_i,
    output dir_inval_t     dir_inval_o,

    output logic           flush_alloc_o,
    input  logic           flush_alloc_ready_i,
    output flush_req_t     flush_alloc_req_o,
    input  logic           flush_empty_i
);

    logic       scan_reset;
    logic       scan_step;
    set_t       scan_set;
    way_vec_t   scan_way;
    logic       scan_set_last;
    logic       scan_way_last;
    logic       flush_push;
    logic       flush_push_ok;
    flush_req_t flush_push_req;

    cmo_fsm fsm_i (
        .clk_i,
        .rst_ni,
        .req_valid_i,
        .req_i,
        .req_ready_o,
        .req_wait_o,
        .status_i,
        .wbuf_flush_all_o,
        .dir_nline_req_o,
        .dir_nline_rsp_i,
        .dir_entry_req_o,
        .dir_entry_rsp_i,
        .dir_inval_o,
        .scan_reset_o    (scan_reset),
        .scan_step_o     (scan_step),
        .scan_set_i      (scan_set),
        .scan_way_i      (scan_way),
        .scan_set_last_i (scan_set_last),
        .scan_way_last_i (scan_way_last),
        .flush_push_o    (flush_push),
        .flush_push_ok_i (flush_push_ok),
        .flush_req_o     (flush_push_req),
        .flush_busy_i    (flush_alloc_o),
        .flush_empty_i
    );

    cmo_scan_cnt scan_i (
        .clk_i,
        .rst_ni,
        .scan_reset_i (scan_reset),
        .scan_step_i  (scan_step),
        .set_o        (scan_set),
        .way_o        (scan_way),
        .set_last_o   (scan_set_last),
        .way_last_o   (scan_way_last)
    );

    // The queue head is offered directly to the flush controller
    cmo_flush_fifo fifo_i (
        .clk_i,
        .rst_ni,
        .push_i      (flush_push),
        .push_ok_o   (flush_push_ok),
        .push_data_i (flush_push_req),
        .pop_i       (flush_alloc_ready_i),
        .pop_ok_o    (flush_alloc_o),
        .pop_data_o  (flush_alloc_req_o)
    );

endmodule

`default_nettype wire

//--- tb/cmo_tb_dir.sv
// Behavioural directory and flush controller model with logs of invalidations and flushes
`default_nettype none
`timescale 1ns/1ps

module cmo_tb_dir
    import cmo_cfg_pkg::*, cmo_if_pkg::*;
(
    input  logic           clk_i,
    input  logic           rst_ni,
    input  dir_nline_req_t dir_nline_req_i,
    output dir_nline_rsp_t dir_nline_rsp_o,
    input  dir_entry_req_t dir_entry_req_i,
    output dir_entry_rsp_t dir_entry_rsp_o,
    input  dir_inval_t     dir_inval_i,
    input  logic           flush_alloc_i,
    input  flush_req_t     flush_alloc_req_i,
    output logic           flush_alloc_ready_o,
    output logic           flush_empty_o
);

    logic        valid_q [CMO_SETS][CMO_WAYS];
    logic        dirty_q [CMO_SETS][CMO_WAYS];
    tag_t        tag_q   [CMO_SETS][CMO_WAYS];
    logic [31:0] lcg_q;
    flush_req_t  flush_log [$];
    dir_inval_t  inval_log [$];

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_entry(int s, int w, logic v, logic d, tag_t t);
        valid_q[s][w] = v;
        dirty_q[s][w] = d;
        tag_q[s][w]   = t;
    endtask

    task automatic clear_logs();
        flush_log.delete();
        inval_log.delete();
    endtask

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dir_nline_rsp_o     <= '0;
            dir_entry_rsp_o     <= '0;
            flush_alloc_ready_o <= 1'b0;
            flush_empty_o       <= 1'b1;
            lcg_q               <= 32'h79cb_0ce9;
        end else begin
            // Answers appear one cycle after the check
            for (int w = 0; w < CMO_WAYS; w++) begin
                dir_nline_rsp_o.hit_way[w] <= valid_q[dir_nline_req_i.set][w] &&
                    (tag_q[dir_nline_req_i.set][w] == dir_nline_req_i.tag);
                if (dir_entry_req_i.way[w]) begin
                    dir_entry_rsp_o <= '{valid: valid_q[dir_entry_req_i.set][w],
                                         dirty: dirty_q[dir_entry_req_i.set][w],
                                         tag:   tag_q[dir_entry_req_i.set][w]};
                end
            end
            dir_nline_rsp_o.dirty <= 1'b0;
            for (int w = 0; w < CMO_WAYS; w++) begin
                if (valid_q[dir_nline_req_i.set][w] && dirty_q[dir_nline_req_i.set][w] &&
                    tag_q[dir_nline_req_i.set][w] == dir_nline_req_i.tag) begin
                    dir_nline_rsp_o.dirty <= 1'b1;
                end
            end
            if (dir_inval_i.valid) begin
                inval_log.push_back(dir_inval_i);
                for (int w = 0; w < CMO_WAYS; w++) begin
                    if (dir_inval_i.way[w]) valid_q[dir_inval_i.set][w] = 1'b0;
                end
            end
            // Random back-pressure from the flush controller
            lcg_q               <= lcg_next(lcg_q);
            flush_alloc_ready_o <= lcg_q[28];
            if (flush_alloc_i && flush_alloc_ready_o) begin
                flush_log.push_back(flush_alloc_req_i);
            end
            flush_empty_o <= !(flush_alloc_i && flush_alloc_ready_o);
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_cmo_handler.sv
// Testbench for the maintenance handler with a stimulus table, checks and watchdog
`default_nettype none
`timescale 1ns/1ps

module tb_cmo_handler
    import cmo_cfg_pkg::*, cmo_if_pkg::*;
();

    localparam int NUM_ROWS = 10;

    // Preload kinds are 0 empty, 1 target clean in way 2, 2 target dirty in way 1 and 3 random
    typedef struct {
        cmo_op_e op;
        addr_t   addr;
        int      kind;
        int      stall;
        int      exp_cnt;
    } row_t;

    logic           clk_i = 1'b0;
    logic           rst_ni;
    logic           req_valid_i;
    cmo_req_t       req_i;
    logic           req_ready_o;
    logic           req_wait_o;
    cache_status_t  status_i;
    logic           wbuf_flush_all_o;
    dir_nline_req_t dir_nline_req_o;
    dir_nline_rsp_t dir_nline_rsp_i;
    dir_entry_req_t dir_entry_req_o;
    dir_entry_rsp_t dir_entry_rsp_i;
    dir_inval_t     dir_inval_o;
    logic           flush_alloc_o;
    logic           flush_alloc_ready_i;
    flush_req_t     flush_alloc_req_o;
    logic           flush_empty_i;

    row_t        rows [NUM_ROWS];
    logic        ref_valid [CMO_SETS][CMO_WAYS];
    logic        ref_dirty [CMO_SETS][CMO_WAYS];
    tag_t        ref_tag   [CMO_SETS][CMO_WAYS];
    flush_req_t  exp_flush [$];
    dir_inval_t  exp_inval [$];
    logic [31:0] rnd = 32'h79cb_0ce9;
    int          errors = 0;
    int          checks = 0;

    always #50 clk_i = ~clk_i;

    cmo_handler dut_i (.*);

    cmo_tb_dir dir_m (
        .clk_i, .rst_ni, .dir_nline_req_i(dir_nline_req_o), .dir_nline_rsp_o(dir_nline_rsp_i),
        .dir_entry_req_i(dir_entry_req_o), .dir_entry_rsp_o(dir_entry_rsp_i),
        .dir_inval_i(dir_inval_o), .flush_alloc_i(flush_alloc_o),
        .flush_alloc_req_i(flush_alloc_req_o), .flush_alloc_ready_o(flush_alloc_ready_i),
        .flush_empty_o(flush_empty_i)
    );

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fill_dir(int kind, addr_t addr);
        logic v;
        logic d;
        tag_t t;
        for (int s = 0; s < CMO_SETS; s++) begin
            for (int w = 0; w < CMO_WAYS; w++) begin
                rnd = lcg_next(rnd);
                v = (kind == 3) ? (rnd[20] | rnd[21]) : 1'b0;
                d = rnd[22];
                // Way number in the low tag bits keeps tags unique within a set
                t = {rnd[30:24], w[1:0]};
                if (kind != 0 && kind != 3 && s == int'(addr[6:4])) begin
                    v = 1'b1;
                    d = (kind == 2);
                    t = addr[15:7] ^ (9'h100 | 9'(w));
                    if ((kind == 1 && w == 2) || (kind == 2 && w == 1)) t = addr[15:7];
                end
                ref_valid[s][w] = v;
                ref_dirty[s][w] = d;
                ref_tag[s][w]   = t;
                dir_m.load_entry(s, w, v, d, t);
            end
        end
    endtask

    // Expected invalidations and flushes from the preloaded contents
    task automatic build_expect(row_t r);
        set_t s;
        exp_flush.delete();
        exp_inval.delete();
        s = r.addr[6:4];
        for (int w = 0; w < CMO_WAYS; w++) begin
            if (ref_valid[s][w] && ref_tag[s][w] == r.addr[15:7]) begin
                if (r.op == CMO_INVAL_NLINE) exp_inval.push_back('{1'b1, s, way_vec_t'(1 << w)});
                if (r.op == CMO_FLUSH_NLINE && ref_dirty[s][w]) begin
                    exp_flush.push_back('{r.addr[15:4], way_vec_t'(1 << w)});
                end
            end
        end
        for (int i = 0; i < CMO_SETS; i++) begin
            if (r.op == CMO_INVAL_ALL) exp_inval.push_back('{1'b1, set_t'(i), 4'hf});
            for (int w = 0; w < CMO_WAYS; w++) begin
                if (r.op == CMO_FLUSH_ALL && ref_valid[i][w] && ref_dirty[i][w]) begin
                    exp_flush.push_back('{{ref_tag[i][w], set_t'(i)}, way_vec_t'(1 << w)});
                end
            end
        end
    endtask

    task automatic wait_ready();
        @(negedge clk_i);
        while (!req_ready_o) @(negedge clk_i);
    endtask

    task automatic compare_logs(row_t r);
        int    n;
        string sig;
        if (r.op inside {CMO_FLUSH_NLINE, CMO_FLUSH_ALL}) begin
            n   = dir_m.flush_log.size();
            sig = "flush_alloc_o";
        end else begin
            n   = dir_m.inval_log.size();
            sig = "dir_inval_o";
        end
        checks += 3;
        if (r.exp_cnt >= 0) begin
            assert (n == r.exp_cnt)
            else begin
                $display("MISMATCH %s count: exp=%0h got=%0h", sig, r.exp_cnt, n);
                errors++;
            end
        end
        assert (dir_m.flush_log.size() == exp_flush.size())
        else begin
            $display("MISMATCH flush_alloc_o count: exp=%0h got=%0h", exp_flush.size(),
                     dir_m.flush_log.size());
            errors++;
        end
        assert (dir_m.inval_log.size() == exp_inval.size())
        else begin
            $display("MISMATCH dir_inval_o count: exp=%0h got=%0h", exp_inval.size(),
                     dir_m.inval_log.size());
            errors++;
        end
        for (int i = 0; i < exp_flush.size() && i < dir_m.flush_log.size(); i++) begin
            assert (dir_m.flush_log[i] == exp_flush[i])
            else begin
                $display("MISMATCH flush_alloc_req_o: exp=%h got=%h", exp_flush[i],
                         dir_m.flush_log[i]);
                errors++;
            end
        end
        for (int i = 0; i < exp_inval.size() && i < dir_m.inval_log.size(); i++) begin
            assert (dir_m.inval_log[i] == exp_inval[i])
            else begin
                $display("MISMATCH dir_inval_o: exp=%h got=%h", exp_inval[i],
                         dir_m.inval_log[i]);
                errors++;
            end
        end
        if (r.op == CMO_INVAL_ALL) begin
            for (int s = 0; s < CMO_SETS; s++) begin
                for (int w = 0; w < CMO_WAYS; w++) begin
                    assert (!dir_m.valid_q[s][w])
                    else begin
                        $display("Line still valid after invalidate all at set %0d", s);
                        errors++;
                    end
                end
            end
        end
    endtask

    // During a fence the write buffer drain request mirrors the replay table state
    task automatic wbuf_flush_follows_rtab();
        checks++;
        assert (wbuf_flush_all_o == status_i.rtab_empty)
        else begin
            $display("MISMATCH wbuf_flush_all_o: exp=%h got=%h", status_i.rtab_empty,
                     wbuf_flush_all_o);
            errors++;
        end
    endtask

    // A fence with nothing to drain leaves the handler ready right away
    task automatic fence_passes_at_once();
        checks++;
        assert (req_ready_o && !req_wait_o)
        else begin
            $display("MISMATCH req_ready_o: exp=1 got=%h (wait=%h)", req_ready_o, req_wait_o);
            errors++;
        end
    endtask

    // Each stalled cycle shows the wait flag, no ready and no directory activity
    task automatic check_stall(row_t r);
        checks++;
        assert (req_wait_o && !req_ready_o)
        else begin
            $display("MISMATCH req_wait_o: exp=1 got=%h (ready=%h)", req_wait_o, req_ready_o);
            errors++;
        end
        assert (!dir_nline_req_o.valid && !dir_entry_req_o.valid && !dir_inval_o.valid)
        else begin
            $display("Directory accessed while waiting for the cache to drain");
            errors++;
        end
        if (r.op == CMO_FENCE) begin
            wbuf_flush_follows_rtab();
        end
    endtask

    initial begin
        rows[0] = '{CMO_FENCE,       16'h0000, 0, 0,  0};
        rows[1] = '{CMO_FENCE,       16'h0000, 0, 6,  0};
        rows[2] = '{CMO_INVAL_NLINE, 16'h3a50, 1, 0,  1};
        rows[3] = '{CMO_INVAL_NLINE, 16'h3a50, 0, 0,  0};
        rows[4] = '{CMO_FLUSH_NLINE, 16'h5c70, 2, 0,  1};
        rows[5] = '{CMO_FLUSH_NLINE, 16'h5c70, 1, 0,  0};
        rows[6] = '{CMO_FLUSH_ALL,   16'h0000, 3, 0, -1};
        rows[7] = '{CMO_FLUSH_ALL,   16'h0000, 3, 5, -1};
        rows[8] = '{CMO_INVAL_NLINE, 16'h9e30, 2, 4,  1};
        rows[9] = '{CMO_INVAL_ALL,   16'h0000, 3, 0,  8};
        rst_ni      = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        status_i    = '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            wait_ready();
            fill_dir(rows[i].kind, rows[i].addr);
            build_expect(rows[i]);
            dir_m.clear_logs();
            @(posedge clk_i);
            req_valid_i <= 1'b1;
            req_i       <= '{rows[i].op, rows[i].addr};
            if (rows[i].stall > 0 && rows[i].op == CMO_FENCE) begin
                status_i.wbuf_empty <= 1'b0;
                status_i.rtab_empty <= 1'b0;
            end else if (rows[i].stall > 0) begin
                status_i.mshr_empty <= 1'b0;
            end
            @(negedge clk_i);
            if (rows[i].op == CMO_FENCE) begin
                wbuf_flush_follows_rtab();
            end
            @(posedge clk_i);
            req_valid_i <= 1'b0;
            if (rows[i].op == CMO_FENCE && rows[i].stall == 0) begin
                @(negedge clk_i);
                fence_passes_at_once();
            end
            for (int c = 0; c < rows[i].stall; c++) begin
                @(negedge clk_i);
                check_stall(rows[i]);
                @(posedge clk_i);
                if (c == rows[i].stall / 2) status_i.rtab_empty <= 1'b1;
                if (c == rows[i].stall - 1) status_i <= '{1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
            end
            wait_ready();
            compare_logs(rows[i]);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        repeat (NUM_ROWS * 200) @(posedge clk_i);
        $display("Timeout: handler did not return to ready");
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/cmo_cfg_pkg.sv
verilog/cmo_if_pkg.sv
verilog/cmo_scan_cnt.sv
verilog/cmo_flush_fifo.sv
verilog/cmo_fsm.sv
verilog/cmo_handler.sv
tb/cmo_tb_dir.sv
tb/tb_cmo_handler.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cmo_handler
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(SIM_LOG)
	@if grep -q "Done: errors found" $(SIM_LOG); then exit 1; fi
	@grep -q "Done: no errors" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
